// File: Bender.yml
package:
  name: approx_divider

sources:
  - files:
      - logic/approx_div_pkg.sv
      - logic/div_cell.sv
      - logic/div_array.sv
      - logic/div_config.sv
      - logic/div_datapath.sv
      - logic/approx_divider_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/approx_divider_tb.sv

// File: include/div_ref_model.svh
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// One cell of the array, returned as {bout, diff}.
function automatic logic [1:0] div_model_cell(input logic x, input logic y,
                                              input logic bin, input logic approx);
  logic diff;
  logic bout;
  if (approx) begin
    bout = (~x & y) | (x & y & bin);
    diff = (x & ~y) | (~x & y & ~bin);
  end else begin
    bout = (~x & y) | (~(x ^ y) & bin);
    diff = x ^ y ^ bin;
  end
  return {bout, diff};
endfunction

// Bit-level model of the triangular array at a given depth.
function automatic approx_div_pkg::div_resp_t div_model_array(
    input approx_div_pkg::div_req_t req, input approx_div_pkg::depth_t depth);
  logic [7:0] rl [8];
  logic [7:0] xs;
  logic [7:0] ds;
  logic [7:0] q;
  logic       b;
  logic       msb;
  logic [1:0] c;
  approx_div_pkg::div_resp_t res;
  for (int i = 7; i >= 0; i--) begin
    b = 1'b0;
    for (int j = 0; j < 8; j++) begin
      if (i == 7) xs[j] = req.n[7+j];
      else        xs[j] = (j == 0) ? req.n[i] : rl[i+1][j-1];
      c = div_model_cell(xs[j], req.d[j], b, (i + j) < int'(depth));
      ds[j] = c[0];
      b = c[1];
    end
    msb = (i == 7) ? req.n[15] : rl[i+1][7];
    q[i] = msb | ~b;
    rl[i] = q[i] ? ds : xs;
  end
  res.q = q;
  res.r = rl[0];
  return res;
endfunction

// True quotient and remainder, truncated to the output width.
function automatic approx_div_pkg::div_resp_t div_model_exact(
    input approx_div_pkg::div_req_t req);
  approx_div_pkg::div_resp_t res;
  res.q = 8'(req.n / req.d);
  res.r = 8'(req.n % req.d);
  return res;
endfunction

`endif

// File: dv/approx_divider_tb.sv
`timescale 1ns/10ps

module approx_divider_tb;

  localparam int CLK_PERIOD = 8;
  localparam int N_EXACT    = 60;
  localparam int N_FULL     = 80;
  localparam int N_MIXED    = 150;
  localparam int N_BURSTS   = 12;
  localparam int MAX_BURST  = 12;
  localparam int MAX_GAP    = 5;
  // Upper bound on the clock cycles that all phases together can take.
  localparam int N_SLOTS = 6 + 1 + N_EXACT * 4 + 1 + N_FULL + N_MIXED
                         + N_BURSTS * (MAX_BURST + MAX_GAP + 1) + 5;

  typedef struct packed {
    approx_div_pkg::div_req_t  op;
    approx_div_pkg::div_resp_t model;
    approx_div_pkg::div_resp_t exact;
    logic                      use_exact;
    logic [31:0]               at;
  } expect_t;

  logic                      clk;
  logic                      arst_n;
  logic                      start;
  approx_div_pkg::div_req_t  req;
  logic                      done;
  approx_div_pkg::div_resp_t resp;
  logic                      cfg_we;
  approx_div_pkg::depth_t    cfg_wdata;
  approx_div_pkg::depth_t    cfg_rdata;

  integer                 seed;
  approx_div_pkg::depth_t model_depth;
  expect_t                exp_q[$];
  int unsigned            neg_idx;
  int unsigned            value_errs;
  int unsigned            other_errs;
  int unsigned            n_started;

  `include "div_ref_model.svh"

  approx_divider_top UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .req       (req),
    .done      (done),
    .resp      (resp),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    int unsigned span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  function automatic approx_div_pkg::div_req_t rand_req_full();
    approx_div_pkg::div_req_t r;
    r.n = 16'(rand_range(0, 65535));
    r.d = 8'(rand_range(0, 255));
    return r;
  endfunction

  // The upper dividend byte stays below the divisor, so the quotient fits in 8 bits.
  function automatic approx_div_pkg::div_req_t rand_req_bounded();
    approx_div_pkg::div_req_t r;
    r.d       = 8'(rand_range(1, 255));
    r.n[15:8] = 8'(rand_range(0, int'(r.d) - 1));
    r.n[7:0]  = 8'(rand_range(0, 255));
    return r;
  endfunction

  task automatic drive_cycle(input logic s, input approx_div_pkg::div_req_t r,
                             input logic we, input approx_div_pkg::depth_t wd);
    @(posedge clk);
    start     <= s;
    req       <= r;
    cfg_we    <= we;
    cfg_wdata <= wd;
  endtask

  task automatic drive_idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
  endtask

  // Inputs and outputs are sampled on the falling edge, away from the driving edge.
  // A start seen here is taken at the next rising edge with the depth in force now.
  // Its done is then seen two falling edges later.
  always @(negedge clk) begin : monitor
    expect_t e;
    if (arst_n) begin
      neg_idx++;
      assert (cfg_rdata == model_depth) else begin
        $display("Fail %0t: cfg_rdata %0d, expected %0d", $time, cfg_rdata, model_depth);
        value_errs++;
      end
      if (done) begin
        assert (exp_q.size() > 0) else begin
          $display("Done pulse at %0t with no operation outstanding", $time);
          other_errs++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          assert (neg_idx == e.at + 2) else begin
            $display("Done at %0t came %0d cycles after its start instead of 1",
                     $time, neg_idx - e.at - 1);
            other_errs++;
          end
          assert (resp == e.model) else begin
            $display("Fail %0t: n=%h d=%h gave q=%h r=%h, model q=%h r=%h", $time,
                     e.op.n, e.op.d, resp.q, resp.r, e.model.q, e.model.r);
            value_errs++;
          end
          if (e.use_exact) begin
            assert (resp == e.exact) else begin
              $display("Fail %0t: n=%h d=%h gave q=%h r=%h, exact q=%h r=%h", $time,
                       e.op.n, e.op.d, resp.q, resp.r, e.exact.q, e.exact.r);
              value_errs++;
            end
          end
        end
      end
      if (start) begin
        e.op        = req;
        e.model     = div_model_array(req, model_depth);
        e.use_exact = (model_depth == 0) && (req.d != 0) && (req.n[15:8] < req.d);
        e.exact     = e.use_exact ? div_model_exact(req) : '0;
        e.at        = neg_idx;
        exp_q.push_back(e);
        n_started++;
      end
      if (cfg_we) begin
        model_depth = cfg_wdata;
      end
    end else begin
      assert (!done) else begin
        $display("Done pulse at %0t while reset is asserted", $time);
        other_errs++;
      end
    end
  end

  initial begin : stimulus
    int len;
    clk         = 1'b0;
    arst_n      = 1'b0;
    start       = 1'b0;
    req         = '0;
    cfg_we      = 1'b0;
    cfg_wdata   = '0;
    seed        = 32'h1d11;
    model_depth = 4'd4;
    neg_idx     = 0;
    value_errs  = 0;
    other_errs  = 0;
    n_started   = 0;

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    drive_idle(2);
    @(negedge clk);
    assert (cfg_rdata == 4'd4) else begin
      $display("Fail %0t: depth after reset is %0d, expected 4", $time, cfg_rdata);
      value_errs++;
    end
    assert (resp == '0) else begin
      $display("Fail %0t: resp after reset is %h, expected 0", $time, resp);
      value_errs++;
    end

    // Exact divider with quotients that fit.
    drive_cycle(1'b0, '0, 1'b1, 4'd0);
    for (int k = 0; k < N_EXACT; k++) begin
      drive_cycle(1'b1, rand_req_bounded(), 1'b0, '0);
      drive_idle(rand_range(0, 3));
    end

    // Reference depth over the full operand range, back to back.
    drive_cycle(1'b0, '0, 1'b1, 4'd4);
    for (int k = 0; k < N_FULL; k++) begin
      drive_cycle(1'b1, rand_req_full(), 1'b0, '0);
    end

    // Writes and starts mixed freely, sometimes in the same cycle.
    for (int k = 0; k < N_MIXED; k++) begin
      drive_cycle(rand_range(0, 1) == 1, rand_req_full(), rand_range(0, 3) == 0,
                  approx_div_pkg::depth_t'(rand_range(0, 15)));
    end

    for (int b = 0; b < N_BURSTS; b++) begin
      drive_cycle(1'b0, '0, 1'b1, approx_div_pkg::depth_t'(rand_range(0, 15)));
      len = rand_range(1, MAX_BURST);
      for (int k = 0; k < len; k++) begin
        drive_cycle(1'b1, rand_req_full(), 1'b0, '0);
      end
      drive_idle(rand_range(1, MAX_GAP));
    end

    drive_idle(5);
    assert (exp_q.size() == 0) else begin
      $display("%0d operations never produced a done pulse", exp_q.size());
      other_errs++;
    end

    $display("Started %0d operations: %0d value errors, %0d other errors",
             n_started, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_SLOTS + 100) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", N_SLOTS + 100);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: logic/approx_div_pkg.sv
package approx_div_pkg;

  // Operand widths of the array. The grid itself is DIVISOR_W rows by DIVISOR_W columns.
  parameter int unsigned DIVIDEND_W = 16;
  parameter int unsigned DIVISOR_W  = 8;

  // Approximation depth.
  // A cell at row i, column j is approximate when i + j is below this value.
  // Zero makes every cell exact; 15 makes all of them approximate.
  typedef logic [3:0] depth_t;

  // Operands presented with a start strobe.
  typedef struct packed {
    logic [DIVIDEND_W-1:0] n;
    logic [DIVISOR_W-1:0]  d;
  } div_req_t;

  // Quotient and remainder presented with the done pulse.
  typedef struct packed {
    logic [DIVISOR_W-1:0] q;
    logic [DIVISOR_W-1:0] r;
  } div_resp_t;

  // Configuration handed from the register block to the datapath.
  typedef struct packed {
    depth_t depth;
  } div_cfg_t;

endpackage

// File: logic/approx_divider_top.sv
`timescale 1ns/10ps

module approx_divider_top #(
  parameter approx_div_pkg::depth_t RESET_DEPTH = 4'd4
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      start,
  input  approx_div_pkg::div_req_t  req,
  output logic                      done,
  output approx_div_pkg::div_resp_t resp,
  input  logic                      cfg_we,
  input  approx_div_pkg::depth_t    cfg_wdata,
  output approx_div_pkg::depth_t    cfg_rdata
);

  approx_div_pkg::div_cfg_t cfg;

  div_config #(
    .RESET_DEPTH (RESET_DEPTH)
  ) u_config (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg)
  );

  div_datapath u_datapath (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .req    (req),
    .cfg    (cfg),
    .done   (done),
    .resp   (resp)
  );

endmodule

// File: logic/div_array.sv
`timescale 1ns/10ps

module div_array (
  input  approx_div_pkg::div_req_t  req,
  input  approx_div_pkg::depth_t    depth,
  output approx_div_pkg::div_resp_t resp
);

  localparam int unsigned W  = approx_div_pkg::DIVISOR_W;
  localparam int unsigned NW = approx_div_pkg::DIVIDEND_W;

  // Restored outputs and borrows of every cell, indexed by row then column.
  // Row W-1 is the first subtraction and row 0 produces the remainder.
  wire [W-1:0] r_loc [W];
  wire [W-1:0] b_loc [W];
  wire [W-1:0] q_bits;

  for (genvar i = 0; i < W; i++) begin : g_row
    wire [W-1:0] x_row;
    wire [W-1:0] bin_row;
    wire         msb_in;

    if (i == W - 1) begin : g_first
      // The first row works on the upper dividend bits directly.
      assign x_row  = req.n[NW-2:W-1];
      assign msb_in = req.n[NW-1];
    end else begin : g_next
      // The row above's remainder, shifted up, with the next dividend bit brought in.
      assign x_row  = {r_loc[i+1][W-2:0], req.n[i]};
      assign msb_in = r_loc[i+1][W-1];
    end

    assign bin_row = {b_loc[i][W-2:0], 1'b0};

    // The subtraction succeeded if the bit shifted out was set or no borrow came out.
    assign q_bits[i] = msb_in | ~b_loc[i][W-1];

    for (genvar j = 0; j < W; j++) begin : g_col
      div_cell u_cell (
        .x      (x_row[j]),
        .y      (req.d[j]),
        .bin    (bin_row[j]),
        .qs     (q_bits[i]),
        .approx (depth > approx_div_pkg::depth_t'(i + j)),
        .r_sub  (r_loc[i][j]),
        .bout   (b_loc[i][j])
      );
    end
  end

  assign resp.q = q_bits;
  assign resp.r = r_loc[0];

endmodule

// File: logic/div_cell.sv
`timescale 1ns/10ps

module div_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  input  logic approx,
  output logic r_sub,
  output logic bout
);

  logic diff_exact;
  logic bout_exact;
  logic diff_approx;
  logic bout_approx;
  logic diff;

  // Exact full subtractor, x - y - bin.
  assign diff_exact = x ^ y ^ bin;
  assign bout_exact = (~x & y) | (~(x ^ y) & bin);

  // Approximate table. The borrow ignores bin unless all inputs are high,
  // and the difference drops the x = y cases entirely.
  assign bout_approx = (~x & y) | (x & y & bin);
  assign diff_approx = (x & ~y) | (~x & y & ~bin);

  assign diff = approx ? diff_approx : diff_exact;
  assign bout = approx ? bout_approx : bout_exact;

  // Restoring step. Keep the partial remainder when the row's quotient bit is zero.
  assign r_sub = qs ? diff : x;

endmodule

// File: logic/div_config.sv
`timescale 1ns/10ps

module div_config #(
  parameter approx_div_pkg::depth_t RESET_DEPTH = 4'd4
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cfg_we,
  input  approx_div_pkg::depth_t   cfg_wdata,
  output approx_div_pkg::depth_t   cfg_rdata,
  output approx_div_pkg::div_cfg_t cfg
);

  approx_div_pkg::depth_t depth_q;

  // Depth register. A write lands on the same edge that samples cfg_we.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      depth_q <= RESET_DEPTH;
    end else if (cfg_we) begin
      depth_q <= cfg_wdata;
    end
  end

  assign cfg_rdata = depth_q;

  // The datapath samples this value on start, so an operation always uses
  // the depth in force before its start edge.
  assign cfg.depth = depth_q;

endmodule

// File: logic/div_datapath.sv
`timescale 1ns/10ps

module div_datapath (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      start,
  input  approx_div_pkg::div_req_t  req,
  input  approx_div_pkg::div_cfg_t  cfg,
  output logic                      done,
  output approx_div_pkg::div_resp_t resp
);

  approx_div_pkg::div_req_t  req_q;
  approx_div_pkg::depth_t    depth_q;
  approx_div_pkg::div_resp_t arr_resp;
  logic                      stage_vld_q;

  // Operand stage. The depth is captured with the operands.
  always_ff @(posedge clk) begin
    if (start) begin
      req_q   <= req;
      depth_q <= cfg.depth;
    end
  end

  div_array u_array (
    .req   (req_q),
    .depth (depth_q),
    .resp  (arr_resp)
  );

  // Result stage, one edge after the operand stage.
  // resp holds the last result between operations.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_vld_q <= 1'b0;
      done        <= 1'b0;
      resp        <= '0;
    end else begin
      stage_vld_q <= start;
      done        <= stage_vld_q;
      if (stage_vld_q) begin
        resp <= arr_resp;
      end
    end
  end

endmodule

// File: vlog.f
+incdir+include
logic/approx_div_pkg.sv
logic/div_cell.sv
logic/div_array.sv
logic/div_config.sv
logic/div_datapath.sv
logic/approx_divider_top.sv
dv/approx_divider_tb.sv
